// File: common/modexp_settings.svh
//~~~~~~~~~~~~~~~~~~~~
// operand size is word width times word count; word count must be even
//~~~~~~~~~~~~~~~~~~~~
`ifndef MODEXP_SETTINGS_SVH
`define MODEXP_SETTINGS_SVH

// width of one CIOS word
`define MODEXP_WORD_W 32

// words per operand, 128 bits by default
`define MODEXP_NUM_WORDS 4

// one load or readout beat carries two words
`define MODEXP_BEAT_W (2 * `MODEXP_WORD_W)

`endif

// File: common/modexp_pkg.sv
//~~~~~~~~~~~~~~~~~~~~
// operands are stored least significant word first
//~~~~~~~~~~~~~~~~~~~~
`include "modexp_settings.svh"

package modexp_pkg;

	typedef logic [`MODEXP_WORD_W-1:0] word_t;
	typedef word_t [`MODEXP_NUM_WORDS-1:0] operand_t;	// word 0 is the low word
	typedef word_t [`MODEXP_BEAT_W/`MODEXP_WORD_W-1:0] beat_t;	// low word in low half

	typedef enum logic [2:0] {
		IDLE, LOAD_E, LOAD_N, LOAD_R, LOAD_T, LOAD_NP, LOAD_M, HELD
	} load_phase_e;

	typedef enum logic [3:0] {
		WAIT_LOAD, WAIT_COMPUTE, TO_MONT, SCAN_E, SQUARE, MULTIPLY,
		FROM_MONT, DONE, READOUT, SPENT
	} exp_phase_e;

	typedef struct packed {
		operand_t a;
		operand_t b;
		operand_t n;
		word_t n0p;	// -n^-1 mod 2^w
	} monpro_req_t;

	typedef struct packed {
		operand_t n;
		word_t n0p;
		operand_t e;
		operand_t r;	// R mod n
		operand_t t;	// R^2 mod n
		operand_t m;
	} keyset_t;

endpackage

// File: monpro/monpro.sv
//~~~~~~~~~~~~~~~~~~~~
// n must be odd and below R; req is held until done
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "modexp_settings.svh"

module monpro
	import modexp_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic start,
	input monpro_req_t req,
	output operand_t product,
	output logic done
);

	localparam int W = `MODEXP_WORD_W;
	localparam int S = `MODEXP_NUM_WORDS;
	localparam int IDX_W = $clog2(S);

	typedef enum logic [2:0] {
		MP_IDLE, MP_MUL, MP_TOP, MP_QUOT, MP_RED, MP_TAIL, MP_CARRY, MP_SUB
	} mp_state_e;

	mp_state_e state;
	logic store_phase;	// 0 issues to the mac, 1 stores its result
	logic [IDX_W-1:0] i_idx;
	logic [IDX_W-1:0] j_idx;
	word_t [S+1:0] v;	// running sum, two spare words on top
	word_t carry;
	word_t q;	// quotient word of this round

	word_t mac_x;
	word_t mac_y;
	word_t mac_z;
	word_t mac_c;
	word_t iss_x;
	word_t iss_y;
	word_t iss_z;
	word_t iss_c;
	logic [2*W-1:0] mac_sum;
	word_t sum_lo;
	word_t sum_hi;
	logic [(S+1)*W:0] diff;

	// x*y + z + c never exceeds 2^(2w) - 1
	assign mac_sum = (2*W)'(mac_x) * (2*W)'(mac_y) + (2*W)'(mac_z) + (2*W)'(mac_c);
	assign sum_lo = mac_sum[W-1:0];
	assign sum_hi = mac_sum[2*W-1:W];

	// top bit set means v is below n
	assign diff = {1'b0, v[S:0]} - {1'b0, word_t'(0), req.n};

	always_comb begin
		iss_x = '0;
		iss_y = '0;
		iss_z = '0;
		iss_c = carry;
		case (state)
			MP_MUL: begin	// v[j] + a[i]*b[j] + C
				iss_x = req.a[i_idx];
				iss_y = req.b[j_idx];
				iss_z = v[j_idx];
			end
			MP_TOP: iss_z = v[S];
			MP_QUOT: begin	// q = v[0]*n0' mod 2^w
				iss_x = v[0];
				iss_y = req.n0p;
				iss_c = '0;
			end
			MP_RED: begin	// v[j] + q*n[j] + C
				iss_x = q;
				iss_y = req.n[j_idx];
				iss_z = v[j_idx];
			end
			MP_TAIL: iss_z = v[S];
			MP_CARRY: iss_z = v[S+1];
			default: iss_c = '0;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= MP_IDLE;
			store_phase <= 1'b0;
			i_idx <= '0;
			j_idx <= '0;
			v <= '0;
			carry <= '0;
			q <= '0;
			mac_x <= '0;
			mac_y <= '0;
			mac_z <= '0;
			mac_c <= '0;
			product <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				MP_IDLE: begin
					if (start) begin
						v <= '0;
						carry <= '0;
						i_idx <= '0;
						j_idx <= '0;
						store_phase <= 1'b0;
						state <= MP_MUL;
					end
				end
				MP_SUB: begin
					if (!diff[(S+1)*W])
						product <= diff[S*W-1:0];	// v >= n
					else
						product <= v[S-1:0];
					done <= 1'b1;
					state <= MP_IDLE;
				end
				default: begin
					if (!store_phase) begin
						mac_x <= iss_x;
						mac_y <= iss_y;
						mac_z <= iss_z;
						mac_c <= iss_c;
						store_phase <= 1'b1;
					end else begin
						store_phase <= 1'b0;
						case (state)
							MP_MUL: begin
								v[j_idx] <= sum_lo;
								carry <= sum_hi;
								if (j_idx == IDX_W'(S - 1)) begin
									j_idx <= '0;
									state <= MP_TOP;
								end else begin
									j_idx <= j_idx + 1'b1;
								end
							end
							MP_TOP: begin
								v[S] <= sum_lo;
								v[S+1] <= sum_hi;
								state <= MP_QUOT;
							end
							MP_QUOT: begin
								q <= sum_lo;
								carry <= '0;
								state <= MP_RED;
							end
							MP_RED: begin
								if (j_idx != '0)
									v[j_idx - 1'b1] <= sum_lo;	// shift down one word
								carry <= sum_hi;
								if (j_idx == IDX_W'(S - 1)) begin
									j_idx <= '0;
									state <= MP_TAIL;
								end else begin
									j_idx <= j_idx + 1'b1;
								end
							end
							MP_TAIL: begin
								v[S-1] <= sum_lo;
								carry <= sum_hi;
								state <= MP_CARRY;
							end
							MP_CARRY: begin
								v[S] <= sum_lo;
								carry <= '0;
								if (i_idx == IDX_W'(S - 1)) begin
									state <= MP_SUB;
								end else begin
									i_idx <= i_idx + 1'b1;
									state <= MP_MUL;
								end
							end
							default: ;
						endcase
					end
				end
			endcase
		end
	end

endmodule

// File: hw/operand_store.sv
//~~~~~~~~~~~~~~~~~~~~
// load_valid low stalls the load; n0' takes one beat, low word only
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "modexp_settings.svh"

module operand_store
	import modexp_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic start_input,
	input logic load_valid,
	input beat_t load_data,
	input logic reload,
	output keyset_t keys,
	output logic loaded,
	output load_phase_e load_phase
);

	localparam int BEATS = `MODEXP_NUM_WORDS / 2;
	localparam int CNT_W = (BEATS > 1) ? $clog2(BEATS) : 1;

	logic [CNT_W-1:0] beat_cnt;
	logic last_beat;
	load_phase_e next_field;

	assign last_beat = (beat_cnt == CNT_W'(BEATS - 1)) || (load_phase == LOAD_NP);

	always_comb begin
		case (load_phase)
			LOAD_E: next_field = LOAD_N;
			LOAD_N: next_field = LOAD_R;
			LOAD_R: next_field = LOAD_T;
			LOAD_T: next_field = LOAD_NP;
			LOAD_NP: next_field = LOAD_M;
			default: next_field = HELD;	// after m
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			load_phase <= IDLE;
			beat_cnt <= '0;
			keys <= '0;
			loaded <= 1'b0;
		end else begin
			loaded <= 1'b0;
			case (load_phase)
				IDLE: begin
					if (start_input) begin
						beat_cnt <= '0;
						load_phase <= LOAD_E;
					end
				end
				HELD: begin
					if (reload) begin	// new message, same key
						beat_cnt <= '0;
						load_phase <= LOAD_M;
					end
				end
				default: begin
					if (load_valid) begin
						case (load_phase)
							LOAD_E: keys.e[2*beat_cnt +: 2] <= load_data;
							LOAD_N: keys.n[2*beat_cnt +: 2] <= load_data;
							LOAD_R: keys.r[2*beat_cnt +: 2] <= load_data;
							LOAD_T: keys.t[2*beat_cnt +: 2] <= load_data;
							LOAD_NP: keys.n0p <= load_data[0];
							LOAD_M: keys.m[2*beat_cnt +: 2] <= load_data;
							default: ;
						endcase
						if (last_beat) begin
							beat_cnt <= '0;
							load_phase <= next_field;
							if (load_phase == LOAD_M)
								loaded <= 1'b1;
						end else begin
							beat_cnt <= beat_cnt + 1'b1;
						end
					end
				end
			endcase
		end
	end

endmodule

// File: hw/exp_sequencer.sv
//~~~~~~~~~~~~~~~~~~~~
// e must be non-zero; run length depends on the bits of e
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "modexp_settings.svh"

module exp_sequencer
	import modexp_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic loaded,
	input logic start_compute,
	input logic get_result,
	input logic load_next,
	input keyset_t keys,
	input logic monpro_done,
	input operand_t product,
	output logic monpro_start,
	output monpro_req_t monpro_req,
	output logic reload,
	output logic result_valid,
	output beat_t result_data,
	output exp_phase_e exp_phase
);

	localparam int W = `MODEXP_WORD_W;
	localparam int S = `MODEXP_NUM_WORDS;
	localparam int BEATS = S / 2;
	localparam int CNT_W = (BEATS > 1) ? $clog2(BEATS) : 1;
	localparam int BIT_W = $clog2(S * W);

	operand_t m_bar;	// m in Montgomery form
	operand_t c_bar;	// running result, Montgomery form until FROM_MONT
	logic [BIT_W-1:0] bit_idx;
	logic [CNT_W-1:0] out_cnt;
	logic waiting;	// product in flight
	logic in_product;
	logic [S*W-1:0] e_flat;
	logic e_bit;
	logic last_bit;

	assign e_flat = keys.e;
	assign e_bit = e_flat[bit_idx];
	assign last_bit = (bit_idx == '0);
	assign in_product = (exp_phase == TO_MONT) || (exp_phase == SQUARE) ||
		(exp_phase == MULTIPLY) || (exp_phase == FROM_MONT);

	// operands stay put while the product runs since c_bar only moves on done
	always_comb begin
		monpro_req.n = keys.n;
		monpro_req.n0p = keys.n0p;
		monpro_req.a = c_bar;
		monpro_req.b = c_bar;
		case (exp_phase)
			TO_MONT: begin
				monpro_req.a = keys.m;
				monpro_req.b = keys.t;
			end
			MULTIPLY: monpro_req.b = m_bar;
			FROM_MONT: begin	// leaves the Montgomery domain
				monpro_req.a = '0;
				monpro_req.a[0] = word_t'(1);
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			exp_phase <= WAIT_LOAD;
			m_bar <= '0;
			c_bar <= '0;
			bit_idx <= '0;
			out_cnt <= '0;
			waiting <= 1'b0;
			monpro_start <= 1'b0;
			reload <= 1'b0;
			result_valid <= 1'b0;
			result_data <= '0;
		end else begin
			monpro_start <= 1'b0;
			reload <= 1'b0;
			result_valid <= 1'b0;
			if (in_product && !waiting) begin
				monpro_start <= 1'b1;
				waiting <= 1'b1;
			end
			if (monpro_done)
				waiting <= 1'b0;
			case (exp_phase)
				WAIT_LOAD: if (loaded) exp_phase <= WAIT_COMPUTE;
				WAIT_COMPUTE: if (start_compute) exp_phase <= TO_MONT;
				TO_MONT: begin
					if (monpro_done) begin
						m_bar <= product;
						c_bar <= keys.r;	// Montgomery form of 1
						bit_idx <= BIT_W'(S * W - 1);
						exp_phase <= SCAN_E;
					end
				end
				SCAN_E: begin	// look for the leading one
					if (e_bit)
						exp_phase <= SQUARE;
					else if (last_bit)
						exp_phase <= FROM_MONT;
					else
						bit_idx <= bit_idx - 1'b1;
				end
				SQUARE: begin
					if (monpro_done) begin
						c_bar <= product;
						if (e_bit) begin
							exp_phase <= MULTIPLY;
						end else if (last_bit) begin
							exp_phase <= FROM_MONT;
						end else begin
							bit_idx <= bit_idx - 1'b1;	// square again
						end
					end
				end
				MULTIPLY: begin
					if (monpro_done) begin
						c_bar <= product;
						if (last_bit) begin
							exp_phase <= FROM_MONT;
						end else begin
							bit_idx <= bit_idx - 1'b1;
							exp_phase <= SQUARE;
						end
					end
				end
				FROM_MONT: begin
					if (monpro_done) begin
						c_bar <= product;
						exp_phase <= DONE;
					end
				end
				DONE: begin
					if (get_result) begin
						out_cnt <= '0;
						exp_phase <= READOUT;
					end
				end
				READOUT: begin	// low beat first, no stalls
					result_valid <= 1'b1;
					result_data <= c_bar[2*out_cnt +: 2];
					if (out_cnt == CNT_W'(BEATS - 1))
						exp_phase <= SPENT;
					else
						out_cnt <= out_cnt + 1'b1;
				end
				SPENT: begin
					if (load_next) begin
						reload <= 1'b1;
						exp_phase <= WAIT_LOAD;
					end
				end
				default: exp_phase <= WAIT_LOAD;
			endcase
		end
	end

endmodule

// File: hw/modexp_top.sv
//~~~~~~~~~~~~~~~~~~~~
// host supplies r, t and n0' along with the key
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module modexp_top
	import modexp_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic start_input,
	input logic load_valid,
	input beat_t load_data,
	input logic start_compute,
	input logic get_result,
	input logic load_next,
	output logic result_valid,
	output beat_t result_data,
	output load_phase_e load_phase,
	output exp_phase_e exp_phase
);

	keyset_t keys;
	logic loaded;
	logic reload;
	monpro_req_t monpro_req;
	logic monpro_start;
	logic monpro_done;
	operand_t product;

	operand_store operand_store_inst (
		.clk(clk),
		.reset(reset),
		.start_input(start_input),
		.load_valid(load_valid),
		.load_data(load_data),
		.reload(reload),
		.keys(keys),
		.loaded(loaded),
		.load_phase(load_phase)
	);

	exp_sequencer exp_sequencer_inst (
		.clk(clk),
		.reset(reset),
		.loaded(loaded),
		.start_compute(start_compute),
		.get_result(get_result),
		.load_next(load_next),
		.keys(keys),
		.monpro_done(monpro_done),
		.product(product),
		.monpro_start(monpro_start),
		.monpro_req(monpro_req),
		.reload(reload),
		.result_valid(result_valid),
		.result_data(result_data),
		.exp_phase(exp_phase)
	);

	monpro monpro_inst (
		.clk(clk),
		.reset(reset),
		.start(monpro_start),
		.req(monpro_req),
		.product(product),
		.done(monpro_done)
	);

endmodule

// File: tb/modexp_ref.svh
//~~~~~~~~~~~~~~~~~~~~
// needs W, OP_W, op_t and wide_t declared before the include
//~~~~~~~~~~~~~~~~~~~~
`ifndef MODEXP_REF_SVH
`define MODEXP_REF_SVH

logic [31:0] lfsr_state = 32'hde41_7dc3;

// fibonacci form, taps for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// one lfsr step per bit taken, lsb first
function automatic wide_t random_bits(input int nbits);
	wide_t val;
	int k;
	val = '0;
	for (k = 0; k < nbits; k++) begin
		val[k] = lfsr_state[31];
		lfsr_state = lfsr_next(lfsr_state);
	end
	return val;
endfunction

function automatic op_t r_mod_n(input op_t n);
	wide_t big_r;
	wide_t res;
	big_r = '0;
	big_r[OP_W] = 1'b1;	// R = 2^(w*s)
	res = big_r % {{OP_W{1'b0}}, n};
	return res[OP_W-1:0];
endfunction

function automatic op_t r_squared_mod_n(input op_t n);
	wide_t r;
	wide_t res;
	r = {{OP_W{1'b0}}, r_mod_n(n)};
	res = (r * r) % {{OP_W{1'b0}}, n};	// r < 2^(w*s) so r*r fits
	return res[OP_W-1:0];
endfunction

// newton iteration, each pass doubles the correct low bits
function automatic word_t n0_prime(input word_t n0);
	word_t inv;
	int bits;
	inv = n0;	// odd n0 is its own inverse mod 8
	for (bits = 3; bits < W; bits = bits * 2)
		inv = inv * (2 - n0 * inv);
	return -inv;
endfunction

// left to right square and multiply with a plain modulo
function automatic op_t power_mod(input op_t m, input op_t e, input op_t n);
	wide_t acc;
	wide_t base;
	wide_t modulus;
	int i;
	acc = 1;
	base = {{OP_W{1'b0}}, m};
	modulus = {{OP_W{1'b0}}, n};
	for (i = OP_W - 1; i >= 0; i--) begin
		acc = (acc * acc) % modulus;
		if (e[i])
			acc = (acc * base) % modulus;
	end
	return acc[OP_W-1:0];
endfunction

`endif

// File: tb/modexp_tb.sv
//~~~~~~~~~~~~~~~~~~~~
// each new key needs a reset, since the store only leaves HELD for a new m
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "modexp_settings.svh"

module modexp_tb
	import modexp_pkg::*;
();

	localparam int W = `MODEXP_WORD_W;
	localparam int S = `MODEXP_NUM_WORDS;
	localparam int BEATS = S / 2;
	localparam int OP_W = W * S;
	localparam int NUM_TESTS = 20;
	localparam int TIMEOUT_CYCLES = NUM_TESTS * 2 * S * (2 * S + 6) * 2 * OP_W + 5000;

	typedef logic [OP_W-1:0] op_t;
	typedef logic [2*OP_W-1:0] wide_t;

	`include "modexp_ref.svh"

	logic clk;
	logic reset;
	logic start_input;
	logic load_valid;
	beat_t load_data;
	logic start_compute;
	logic get_result;
	logic load_next;
	logic result_valid;
	beat_t result_data;
	load_phase_e load_phase;
	exp_phase_e exp_phase;

	string test_name = "reset";
	op_t expected_q[$];
	op_t got;
	op_t want;
	int beat_idx = 0;
	int results_expected = 0;
	int results_seen = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int error_count = 0;
	int cycle_count = 0;

	modexp_top modexp_top_inst (
		.clk(clk),
		.reset(reset),
		.start_input(start_input),
		.load_valid(load_valid),
		.load_data(load_data),
		.start_compute(start_compute),
		.get_result(get_result),
		.load_next(load_next),
		.result_valid(result_valid),
		.result_data(result_data),
		.load_phase(load_phase),
		.exp_phase(exp_phase)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: test %0s stalled after %0d cycles", test_name, cycle_count);
			$display("Simulation failed");
			$finish;
		end
	end

	// gathers the readout beats, low beat first, and checks each result
	always @(negedge clk) begin
		if (reset) begin
			beat_idx = 0;
		end else if (result_valid) begin
			got[beat_idx*2*W +: 2*W] = result_data;
			beat_idx = beat_idx + 1;
			if (beat_idx == BEATS) begin
				beat_idx = 0;
				tests_run++;
				results_seen++;
				if (expected_q.size() == 0) begin
					$display("A result came out during test %0s with none expected", test_name);
					error_count++;
					tests_failed++;
				end else begin
					want = expected_q.pop_front();
					if (got !== want) begin
						$display("Error at %0t: %0s expected %h, got %h",
							$time, test_name, want, got);
						error_count++;
						tests_failed++;
						$display("test %0s: mismatch", test_name);
					end else begin
						$display("test %0s: ok", test_name);
					end
				end
			end
		end else if (beat_idx != 0) begin	// beats must be back to back
			$display("Readout of test %0s broke off after %0d beats", test_name, beat_idx);
			void'(expected_q.pop_front());
			error_count++;
			tests_failed++;
			tests_run++;
			results_seen++;
			beat_idx = 0;
		end
	end

	task automatic until_exp_phase(input exp_phase_e target);
		@(negedge clk);
		while (exp_phase != target)
			@(negedge clk);
	endtask

	task automatic wait_store_phase(input load_phase_e target);
		@(negedge clk);
		while (load_phase != target)
			@(negedge clk);
	endtask

	task automatic apply_reset();
		@(posedge clk);
		reset <= 1'b1;
		start_input <= 1'b0;
		load_valid <= 1'b0;
		load_data <= '0;
		start_compute <= 1'b0;
		get_result <= 1'b0;
		load_next <= 1'b0;
		repeat (16) @(posedge clk);
		reset <= 1'b0;
	endtask

	task automatic send_beat(input beat_t b);
		@(posedge clk);
		while (random_bits(2) == 0) begin	// idle gap, data is junk
			load_valid <= 1'b0;
			load_data <= '1;
			@(posedge clk);
		end
		load_valid <= 1'b1;
		load_data <= b;
	endtask

	task automatic send_operand(input op_t op);
		int k;
		for (k = 0; k < BEATS; k++)
			send_beat(op[k*2*W +: 2*W]);
	endtask

	task automatic load_all(input op_t e, input op_t n, input op_t m);
		beat_t np_beat;
		np_beat = '0;
		np_beat[0] = n0_prime(n[W-1:0]);
		@(posedge clk);
		start_input <= 1'b1;
		@(posedge clk);
		start_input <= 1'b0;
		wait_store_phase(LOAD_E);
		send_operand(e);
		send_operand(n);
		send_operand(r_mod_n(n));
		send_operand(r_squared_mod_n(n));
		send_beat(np_beat);	// n0' uses the low word
		send_operand(m);
		@(posedge clk);
		load_valid <= 1'b0;
		until_exp_phase(WAIT_COMPUTE);
		if (load_phase != HELD) begin
			$display("Error at %0t: %0s expected load_phase %0d after load, got %0d",
				$time, test_name, HELD, load_phase);
			error_count++;
		end
	endtask

	// new message under the key already held
	task automatic load_message(input op_t m);
		@(posedge clk);
		load_next <= 1'b1;
		@(posedge clk);
		load_next <= 1'b0;
		wait_store_phase(LOAD_M);
		send_operand(m);
		@(posedge clk);
		load_valid <= 1'b0;
		until_exp_phase(WAIT_COMPUTE);
	endtask

	task automatic run_compute(input string name, input op_t e, input op_t n, input op_t m);
		test_name = name;
		expected_q.push_back(power_mod(m, e, n));
		results_expected++;
		@(posedge clk);
		start_compute <= 1'b1;
		@(posedge clk);
		start_compute <= 1'b0;
		until_exp_phase(DONE);
		@(posedge clk);
		get_result <= 1'b1;
		@(posedge clk);
		get_result <= 1'b0;
		until_exp_phase(SPENT);
		while (results_seen != results_expected)
			@(negedge clk);
	endtask

	task automatic full_run(input string name, input op_t e, input op_t n, input op_t m);
		test_name = name;
		apply_reset();
		load_all(e, n, m);
		run_compute(name, e, n, m);
	endtask

	function automatic op_t random_modulus();
		wide_t raw;
		raw = random_bits(OP_W);
		raw[OP_W-1] = 1'b1;	// full width
		raw[0] = 1'b1;	// odd
		return raw[OP_W-1:0];
	endfunction

	function automatic op_t random_below(input op_t n);
		wide_t raw;
		raw = random_bits(OP_W) % {{OP_W{1'b0}}, n};
		return raw[OP_W-1:0];
	endfunction

	function automatic op_t random_exponent();
		wide_t raw;
		raw = random_bits(OP_W);
		if (raw == '0)
			raw = 1;
		return raw[OP_W-1:0];
	endfunction

	initial begin
		op_t n;
		op_t e;
		op_t m;
		int k;
		clk = 1'b0;
		reset = 1'b1;
		start_input = 1'b0;
		load_valid = 1'b0;
		load_data = '0;
		start_compute = 1'b0;
		get_result = 1'b0;
		load_next = 1'b0;

		apply_reset();
		@(negedge clk);
		tests_run++;
		if (load_phase !== IDLE || exp_phase !== WAIT_LOAD || result_valid !== 1'b0) begin
			$display("Error at %0t: after reset expected load_phase %0d, exp_phase %0d, %s",
				$time, IDLE, WAIT_LOAD, "result_valid 0");
			$display("Error at %0t: after reset got load_phase %0d, exp_phase %0d, %s %b",
				$time, load_phase, exp_phase, "result_valid", result_valid);
			error_count++;
			tests_failed++;
			$display("test reset: mismatch");
		end else begin
			$display("test reset: ok");
		end

		n = random_modulus();
		full_run("e_one", 1, n, random_below(n));
		full_run("e_three", 3, n, random_below(n));
		full_run("m_zero", random_exponent(), n, 0);
		full_run("m_one", random_exponent(), n, 1);

		for (k = 0; k < 10; k++) begin
			n = random_modulus();
			e = random_exponent();
			full_run($sformatf("random_%0d", k), e, n, random_below(n));
		end

		// key from the last random run stays loaded
		for (k = 0; k < 2; k++) begin
			m = random_below(n);
			test_name = $sformatf("reload_%0d", k);
			load_message(m);
			run_compute(test_name, e, n, m);
		end

		n = random_modulus();
		e = '0;
		e[OP_W-1] = 1'b1;
		full_run("e_top_bit", e, n, random_below(n));
		e = '1;
		full_run("e_all_ones", e, n, random_below(n));

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, error_count);
		if (error_count == 0 && tests_failed == 0 && results_seen == results_expected) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: project.f
+incdir+common
+incdir+tb
common/modexp_pkg.sv
monpro/monpro.sv
hw/operand_store.sv
hw/exp_sequencer.sv
hw/modexp_top.sv
tb/modexp_tb.sv
